// File: sim.f
src/axi_sram_pkg.sv
src/axi_beat_addr.sv
src/sram_bank.sv
src/axi_write_engine.sv
src/axi_read_engine.sv
src/axi_burst_sram.sv
testbench/tb_axi_burst_sram_assert.sv
testbench/tb_axi_burst_sram.sv

// File: src/axi_beat_addr.sv
`timescale 1ns/100ps
`default_nettype none

module axi_beat_addr (
    input  wire  [axi_sram_pkg::MEM_ADDR_BITS-1:0] addr,
    input  wire  [axi_sram_pkg::LEN_W-1:0]         len,
    input  wire  axi_sram_pkg::burst_e             burst,
    output logic [axi_sram_pkg::MEM_ADDR_BITS-1:0] next_addr
);

    logic [axi_sram_pkg::MEM_ADDR_BITS-1:0] incr_addr;
    logic [axi_sram_pkg::MEM_ADDR_BITS-1:0] wrap_mask;
    logic                                   wrap_ok;

    assign incr_addr = addr + 1'b1;

    // Legal wrap lengths are 2, 4, 8 and 16 beats
    assign wrap_ok = (len == 4'd1) || (len == 4'd3) || (len == 4'd7) || (len == 4'd15);

    // For those lengths the beat count minus one is the mask itself
    assign wrap_mask = {{(axi_sram_pkg::MEM_ADDR_BITS - axi_sram_pkg::LEN_W){1'b0}}, len};

    always_comb begin
        case (burst)
            axi_sram_pkg::FIXED: begin
                next_addr = addr;
            end
            axi_sram_pkg::WRAP: begin
                if (wrap_ok) begin
                    // Upper bits stay, low bits roll over inside the block
                    next_addr = (addr & ~wrap_mask) | (incr_addr & wrap_mask);
                end else begin
                    next_addr = incr_addr; // Odd length served as INCR
                end
            end
            default: begin
                next_addr = incr_addr; // INCR and the reserved code
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/axi_burst_sram.sv
`timescale 1ns/100ps
`default_nettype none

module axi_burst_sram (
    input  wire                         ACLK,
    input  wire                         ARESETn,
    input  wire  axi_sram_pkg::axi_aw_t aw,
    input  wire                         aw_valid,
    output logic                        aw_ready,
    input  wire  axi_sram_pkg::axi_w_t  w,
    input  wire                         w_valid,
    output logic                        w_ready,
    output axi_sram_pkg::axi_b_t        b,
    output logic                        b_valid,
    input  wire                         b_ready,
    input  wire  axi_sram_pkg::axi_ar_t ar,
    input  wire                         ar_valid,
    output logic                        ar_ready,
    output axi_sram_pkg::axi_r_t        r,
    output logic                        r_valid,
    input  wire                         r_ready
);

    // Memory write port
    logic                                   wr_en;
    logic [axi_sram_pkg::MEM_ADDR_BITS-1:0] wr_addr;
    logic [axi_sram_pkg::DATA_W-1:0]        wr_data;
    logic [axi_sram_pkg::STRB_W-1:0]        wr_strb;

    // Memory read port
    logic                                   rd_en;
    logic [axi_sram_pkg::MEM_ADDR_BITS-1:0] rd_addr;
    logic [axi_sram_pkg::DATA_W-1:0]        rd_data;

    axi_write_engine u_wr (
        .ACLK     (ACLK),
        .ARESETn  (ARESETn),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .b        (b),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wr_strb  (wr_strb)
    );

    axi_read_engine u_rd (
        .ACLK     (ACLK),
        .ARESETn  (ARESETn),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    sram_bank u_mem (
        .ACLK    (ACLK),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_strb (wr_strb),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// File: src/axi_read_engine.sv
`timescale 1ns/100ps
`default_nettype none

module axi_read_engine (
    input  wire                                    ACLK,
    input  wire                                    ARESETn,
    input  wire  axi_sram_pkg::axi_ar_t            ar,
    input  wire                                    ar_valid,
    output logic                                   ar_ready,
    output axi_sram_pkg::axi_r_t                   r,
    output logic                                   r_valid,
    input  wire                                    r_ready,
    output logic                                   rd_en,
    output logic [axi_sram_pkg::MEM_ADDR_BITS-1:0] rd_addr,
    input  wire  [axi_sram_pkg::DATA_W-1:0]        rd_data
);

    axi_sram_pkg::rd_state_e                state;
    logic [axi_sram_pkg::ID_W-1:0]          id_q;
    logic [axi_sram_pkg::MEM_ADDR_BITS-1:0] addr_q;   // Word of the current beat
    logic [axi_sram_pkg::LEN_W-1:0]         len_q;
    axi_sram_pkg::burst_e                   burst_q;
    logic                                   err_q;
    logic [axi_sram_pkg::LEN_W-1:0]         cnt_q;    // Beats already sent
    logic [axi_sram_pkg::MEM_ADDR_BITS-1:0] next_addr;
    logic [axi_sram_pkg::MEM_ADDR_BITS-1:0] ar_word;
    logic                                   ar_hs;
    logic                                   r_hs;
    logic                                   last_beat;

    assign ar_ready = (state == axi_sram_pkg::RD_ADDR);
    assign r_valid  = (state == axi_sram_pkg::RD_DATA);

    assign ar_hs     = ar_valid && ar_ready;
    assign r_hs      = r_valid && r_ready;
    assign last_beat = (cnt_q == len_q);
    assign ar_word   = ar.addr[axi_sram_pkg::MEM_ADDR_BITS+1:2];

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            state <= axi_sram_pkg::RD_ADDR;
            cnt_q <= '0;
        end else begin
            case (state)
                axi_sram_pkg::RD_ADDR: begin
                    if (ar_hs) begin
                        state <= axi_sram_pkg::RD_FETCH;
                        cnt_q <= '0;
                    end
                end
                axi_sram_pkg::RD_FETCH: begin
                    state <= axi_sram_pkg::RD_DATA; // Word lands in rd_data now
                end
                axi_sram_pkg::RD_DATA: begin
                    if (r_hs) begin
                        cnt_q <= cnt_q + 1'b1;
                        state <= last_beat ? axi_sram_pkg::RD_ADDR : axi_sram_pkg::RD_FETCH;
                    end
                end
                default: state <= axi_sram_pkg::RD_ADDR;
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (ar_hs) begin
            id_q    <= ar.id;
            addr_q  <= ar_word;
            len_q   <= ar.len;
            burst_q <= ar.burst;
            err_q   <= (ar.addr[axi_sram_pkg::ADDR_W-1:axi_sram_pkg::MEM_ADDR_BITS+2] != '0);
        end else if (r_hs && !last_beat) begin
            addr_q  <= next_addr;
        end
    end

    axi_beat_addr u_next (
        .addr      (addr_q),
        .len       (len_q),
        .burst     (burst_q),
        .next_addr (next_addr)
    );

    // Fetch the first word at AR and each later word at the R handshake
    assign rd_en   = ar_hs || (r_hs && !last_beat);
    assign rd_addr = (state == axi_sram_pkg::RD_ADDR) ? ar_word : next_addr;

    // Everything here is register driven, so it holds under back-pressure
    always_comb begin
        r.id   = id_q;
        r.data = err_q ? '0 : rd_data;
        r.resp = err_q ? axi_sram_pkg::SLVERR : axi_sram_pkg::OKAY;
        r.last = last_beat;
    end

endmodule

`default_nettype wire

// File: src/axi_sram_pkg.sv
`default_nettype none

package axi_sram_pkg;

    // Bus and memory sizes
    localparam int ADDR_W        = 32;
    localparam int DATA_W        = 32;
    localparam int STRB_W        = DATA_W / 8;
    localparam int ID_W          = 4;
    localparam int LEN_W         = 4;   // Up to 16 beats
    localparam int MEM_ADDR_BITS = 10;  // 1024 words

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } burst_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_e;

    typedef enum logic [1:0] {
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    typedef enum logic [1:0] {
        RD_ADDR,
        RD_FETCH,
        RD_DATA
    } rd_state_e;

    // Address channels share one layout
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;   // Beats minus one
        burst_e            burst;
    } axi_aw_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        burst_e            burst;
    } axi_ar_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        resp_e           resp;
    } axi_b_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        resp_e             resp;
        logic              last;
    } axi_r_t;

endpackage

`default_nettype wire

// File: src/axi_write_engine.sv
`timescale 1ns/100ps
`default_nettype none

module axi_write_engine (
    input  wire                                    ACLK,
    input  wire                                    ARESETn,
    input  wire  axi_sram_pkg::axi_aw_t            aw,
    input  wire                                    aw_valid,
    output logic                                   aw_ready,
    input  wire  axi_sram_pkg::axi_w_t             w,
    input  wire                                    w_valid,
    output logic                                   w_ready,
    output axi_sram_pkg::axi_b_t                   b,
    output logic                                   b_valid,
    input  wire                                    b_ready,
    output logic                                   wr_en,
    output logic [axi_sram_pkg::MEM_ADDR_BITS-1:0] wr_addr,
    output logic [axi_sram_pkg::DATA_W-1:0]        wr_data,
    output logic [axi_sram_pkg::STRB_W-1:0]        wr_strb
);

    axi_sram_pkg::wr_state_e                state;
    logic [axi_sram_pkg::ID_W-1:0]          id_q;
    logic [axi_sram_pkg::MEM_ADDR_BITS-1:0] addr_q;
    logic [axi_sram_pkg::LEN_W-1:0]         len_q;
    axi_sram_pkg::burst_e                   burst_q;
    logic                                   err_q;   // Start address out of range
    logic [axi_sram_pkg::MEM_ADDR_BITS-1:0] next_addr;
    logic                                   aw_hs;
    logic                                   w_hs;

    assign aw_ready = (state == axi_sram_pkg::WR_ADDR);
    assign w_ready  = (state == axi_sram_pkg::WR_DATA);
    assign b_valid  = (state == axi_sram_pkg::WR_RESP);

    assign aw_hs = aw_valid && aw_ready;
    assign w_hs  = w_valid && w_ready;

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            state <= axi_sram_pkg::WR_ADDR;
        end else begin
            case (state)
                axi_sram_pkg::WR_ADDR: if (aw_hs) state <= axi_sram_pkg::WR_DATA;
                axi_sram_pkg::WR_DATA: if (w_hs && w.last) state <= axi_sram_pkg::WR_RESP;
                axi_sram_pkg::WR_RESP: if (b_ready) state <= axi_sram_pkg::WR_ADDR;
                default:               state <= axi_sram_pkg::WR_ADDR;
            endcase
        end
    end

    // Burst context, loaded at AW and stepped per beat
    always_ff @(posedge ACLK) begin
        if (aw_hs) begin
            id_q    <= aw.id;
            addr_q  <= aw.addr[axi_sram_pkg::MEM_ADDR_BITS+1:2];
            len_q   <= aw.len;
            burst_q <= aw.burst;
            err_q   <= (aw.addr[axi_sram_pkg::ADDR_W-1:axi_sram_pkg::MEM_ADDR_BITS+2] != '0);
        end else if (w_hs) begin
            addr_q  <= next_addr;
        end
    end

    axi_beat_addr u_next (
        .addr      (addr_q),
        .len       (len_q),
        .burst     (burst_q),
        .next_addr (next_addr)
    );

    // Beats go straight to the memory, dropped when out of range
    assign wr_en   = w_hs && !err_q;
    assign wr_addr = addr_q;
    assign wr_data = w.data;
    assign wr_strb = w.strb;

    always_comb begin
        b.id   = id_q;
        b.resp = err_q ? axi_sram_pkg::SLVERR : axi_sram_pkg::OKAY;
    end

endmodule

`default_nettype wire

// File: src/sram_bank.sv
`timescale 1ns/100ps
`default_nettype none

module sram_bank (
    input  wire                                    ACLK,
    input  wire                                    wr_en,
    input  wire  [axi_sram_pkg::MEM_ADDR_BITS-1:0] wr_addr,
    input  wire  [axi_sram_pkg::DATA_W-1:0]        wr_data,
    input  wire  [axi_sram_pkg::STRB_W-1:0]        wr_strb,
    input  wire                                    rd_en,
    input  wire  [axi_sram_pkg::MEM_ADDR_BITS-1:0] rd_addr,
    output logic [axi_sram_pkg::DATA_W-1:0]        rd_data
);

    logic [axi_sram_pkg::DATA_W-1:0] mem [0:(1 << axi_sram_pkg::MEM_ADDR_BITS)-1];

    // Byte lanes written one by one under their strobe
    always_ff @(posedge ACLK) begin
        if (wr_en) begin
            for (int i = 0; i < axi_sram_pkg::STRB_W; i++) begin
                if (wr_strb[i]) begin
                    mem[wr_addr][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end
    end

    // Output register holds its word until the next fetch
    always_ff @(posedge ACLK) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_axi_burst_sram.sv
`timescale 1ns/100ps
`default_nettype none

module tb_axi_burst_sram;

    localparam int TMO = 200;  // Cycles allowed for any one wait

    logic                  ACLK;
    logic                  ARESETn;
    axi_sram_pkg::axi_aw_t aw;
    logic                  aw_valid;
    logic                  aw_ready;
    axi_sram_pkg::axi_w_t  w;
    logic                  w_valid;
    logic                  w_ready;
    axi_sram_pkg::axi_b_t  b;
    logic                  b_valid;
    logic                  b_ready;
    axi_sram_pkg::axi_ar_t ar;
    logic                  ar_valid;
    logic                  ar_ready;
    axi_sram_pkg::axi_r_t  r;
    logic                  r_valid;
    logic                  r_ready;

    logic [31:0] model [0:1023];  // Reference memory with one word per entry
    logic [31:0] seed;
    string       cur_test;
    bit          jitter;          // Random stalls on b_ready and r_ready
    int          errors;
    int          checks;
    int          tests;
    int          failed_tests;

    axi_burst_sram u_dut (.*);

    initial begin
        ACLK = 1'b0;
        forever #10 ACLK = ~ACLK;
    end

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Next word of a burst under the AXI burst rules
    function automatic logic [9:0] step_addr(logic [9:0] a, logic [3:0] len,
                                             axi_sram_pkg::burst_e burst);
        int beats;
        int base;
        beats = int'(len) + 1;
        base  = (int'(a) / beats) * beats;  // Start of the wrap block
        if (burst == axi_sram_pkg::FIXED) return a;
        if (burst == axi_sram_pkg::WRAP &&
            (beats == 2 || beats == 4 || beats == 8 || beats == 16))
            return 10'(base + (int'(a) - base + 1) % beats);
        return a + 10'd1;
    endfunction

    function automatic logic [31:0] fill_word(logic [9:0] a);
        return {a, 6'h2a, ~a, 6'h15};
    endfunction

    function automatic logic [31:0] byte_addr(logic [9:0] word);
        return {20'd0, word, 2'b00};
    endfunction

    task automatic check(string field, logic [31:0] exp, logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %s %s expected %h actual %h", cur_test, field, exp, act);
        end
    endtask

    task automatic abort_on_timeout(string what);
        $display("Timeout in %s while waiting for %s", cur_test, what);
        $display("Test failures found");
        $finish;
    endtask

    task automatic write_burst(logic [31:0] addr, logic [3:0] len,
                               axi_sram_pkg::burst_e burst, bit fill);
        logic [31:0] rnd;
        logic [9:0]  a;
        logic [3:0]  id;
        logic [31:0] data;
        logic [3:0]  strb;
        bit          oor;
        int          n;
        a   = addr[11:2];
        oor = (addr[31:12] != 20'd0);
        rnd = next_random();
        id  = rnd[3:0];
        aw  = '{id: id, addr: addr, len: len, burst: burst};
        aw_valid = 1'b1;
        n = 0;
        while (!aw_ready) begin
            if (++n > TMO) abort_on_timeout("aw_ready");
            @(negedge ACLK);
        end
        @(negedge ACLK);
        aw_valid = 1'b0;
        for (int i = 0; i <= len; i++) begin
            rnd  = next_random();
            strb = fill ? 4'hf : rnd[19:16];
            rnd  = next_random();
            data = fill ? fill_word(a) : rnd;
            w    = '{data: data, strb: strb, last: (i == len)};
            w_valid = 1'b1;
            n = 0;
            while (!w_ready) begin
                if (++n > TMO) abort_on_timeout("w_ready");
                @(negedge ACLK);
            end
            for (int k = 0; k < 4; k++) begin
                if (strb[k] && !oor) model[a][8*k +: 8] = data[8*k +: 8];
            end
            a = step_addr(a, len, burst);
            @(negedge ACLK);
        end
        w_valid = 1'b0;
        n = 0;
        while (!b_valid) begin
            if (++n > TMO) abort_on_timeout("b_valid");
            @(negedge ACLK);
        end
        rnd = next_random();
        repeat (jitter ? rnd[2:0] : 0) @(negedge ACLK);
        check("bid", id, b.id);
        check("bresp", oor ? axi_sram_pkg::SLVERR : axi_sram_pkg::OKAY, b.resp);
        b_ready = 1'b1;
        @(negedge ACLK);
        b_ready = 1'b0;
    endtask

    task automatic read_burst(logic [31:0] addr, logic [3:0] len,
                              axi_sram_pkg::burst_e burst);
        logic [31:0] rnd;
        logic [9:0]  a;
        logic [3:0]  id;
        bit          oor;
        int          n;
        a   = addr[11:2];
        oor = (addr[31:12] != 20'd0);
        rnd = next_random();
        id  = rnd[3:0];
        ar  = '{id: id, addr: addr, len: len, burst: burst};
        ar_valid = 1'b1;
        n = 0;
        while (!ar_ready) begin
            if (++n > TMO) abort_on_timeout("ar_ready");
            @(negedge ACLK);
        end
        @(negedge ACLK);
        ar_valid = 1'b0;
        for (int i = 0; i <= len; i++) begin
            n = 0;
            while (!r_valid) begin
                if (++n > TMO) abort_on_timeout("r_valid");
                @(negedge ACLK);
            end
            rnd = next_random();
            repeat (jitter ? rnd[2:0] : 0) @(negedge ACLK);
            check("rid", id, r.id);
            check("rdata", oor ? 32'd0 : model[a], r.data);
            check("rresp", oor ? axi_sram_pkg::SLVERR : axi_sram_pkg::OKAY, r.resp);
            check("rlast", (i == len), r.last);
            r_ready = 1'b1;
            @(negedge ACLK);
            r_ready = 1'b0;
            a = step_addr(a, len, burst);
        end
    endtask

    task automatic end_test(int err_before);
        tests++;
        if (errors != err_before) failed_tests++;
        $display("%-12s %s (%0d errors)", cur_test,
                 (errors == err_before) ? "ok" : "FAILED", errors - err_before);
    endtask

    initial begin
        int                   e0;
        logic [31:0]          rnd;
        logic [9:0]           word;
        logic [31:0]          wa;
        logic [3:0]           wl;
        axi_sram_pkg::burst_e wb;
        aw       = '0;
        aw_valid = 1'b0;
        w        = '0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        ar       = '0;
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        ARESETn  = 1'b0;
        seed     = 32'h07bd2709;
        jitter   = 1'b0;
        errors   = 0;
        checks   = 0;
        tests    = 0;
        failed_tests = 0;
        cur_test = "fill";
        repeat (2) @(posedge ACLK);
        @(negedge ACLK);
        ARESETn = 1'b1;

        // Whole memory gets a known pattern first
        for (int k = 0; k < 64; k++) write_burst(k * 64, 4'd15, axi_sram_pkg::INCR, 1'b1);

        cur_test = "single_beat";
        e0 = errors;
        repeat (8) begin
            rnd = next_random();
            write_burst(byte_addr(rnd[9:0]), 4'd0, axi_sram_pkg::INCR, 1'b0);
            read_burst(byte_addr(rnd[9:0]), 4'd0, axi_sram_pkg::INCR);
        end
        end_test(e0);

        cur_test = "incr_burst";
        e0 = errors;
        repeat (10) begin
            rnd  = next_random();
            word = rnd[9:0] % 1008;
            write_burst(byte_addr(word), rnd[13:10], axi_sram_pkg::INCR, 1'b0);
            read_burst(byte_addr(word), rnd[13:10], axi_sram_pkg::INCR);
        end
        end_test(e0);

        cur_test = "wrap_burst";
        e0 = errors;
        for (int j = 1; j <= 15; j = 2 * j + 1) begin
            rnd  = next_random();
            word = rnd[9:0] | 10'd1;  // Odd word is never block aligned
            write_burst(byte_addr(word), 4'(j), axi_sram_pkg::WRAP, 1'b0);
            read_burst(byte_addr(word), 4'(j), axi_sram_pkg::WRAP);
            read_burst(byte_addr(word & ~10'(j)), 4'(j), axi_sram_pkg::INCR);
        end
        end_test(e0);

        cur_test = "fixed_burst";
        e0 = errors;
        repeat (4) begin
            rnd = next_random();
            write_burst(byte_addr(rnd[9:0]), {1'b0, rnd[12:10]}, axi_sram_pkg::FIXED, 1'b0);
            read_burst(byte_addr(rnd[9:0]), {1'b0, rnd[12:10]}, axi_sram_pkg::FIXED);
        end
        end_test(e0);

        cur_test = "out_of_range";
        e0 = errors;
        repeat (4) begin
            rnd = next_random();
            wa  = {rnd[31:13], 1'b1, rnd[9:0], 2'b00};
            write_burst(wa, {2'b00, rnd[11:10]}, axi_sram_pkg::INCR, 1'b0);
            read_burst(wa, {2'b00, rnd[11:10]}, axi_sram_pkg::INCR);
            read_burst(byte_addr(rnd[9:0]), {2'b00, rnd[11:10]}, axi_sram_pkg::INCR);
        end
        end_test(e0);

        // Writes go to the upper half and reads to the lower half
        cur_test = "concurrent";
        e0 = errors;
        jitter = 1'b1;
        repeat (6) begin
            rnd = next_random();
            wa  = byte_addr(10'd512 + rnd[7:0]);
            wl  = rnd[11:8];
            wb  = rnd[12] ? axi_sram_pkg::WRAP : axi_sram_pkg::INCR;
            fork
                write_burst(wa, wl, wb, 1'b0);
                read_burst(byte_addr({2'b00, rnd[23:16]}), rnd[27:24], axi_sram_pkg::INCR);
            join
            read_burst(wa, wl, wb);
        end
        jitter = 1'b0;
        end_test(e0);

        errors = errors + u_dut.u_assert.fail_count;
        $display("Summary: %0d tests, %0d failing, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_axi_burst_sram_assert.sv
`timescale 1ns/100ps
`default_nettype none

module tb_axi_burst_sram_assert (
    input wire                        ACLK,
    input wire                        ARESETn,
    input wire                        aw_ready,
    input wire axi_sram_pkg::axi_w_t  w,
    input wire                        w_valid,
    input wire                        w_ready,
    input wire                        b_valid,
    input wire                        b_ready,
    input wire axi_sram_pkg::axi_r_t  r,
    input wire                        r_valid,
    input wire                        r_ready
);

    logic last_seen; // W beat with last accepted and B not yet taken
    int   fail_count = 0;

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            last_seen <= 1'b0;
        end else if (w_valid && w_ready && w.last) begin
            last_seen <= 1'b1;
        end else if (b_valid && b_ready) begin
            last_seen <= 1'b0;
        end
    end

    aw_b_exclusive: assert property (@(posedge ACLK) disable iff (!ARESETn)
        !(aw_ready && b_valid))
        else begin
            $error("aw_ready and b_valid high in the same cycle");
            fail_count++;
        end

    // Stalled R beat must not change
    r_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (r_valid && !r_ready) |=> (r_valid && $stable(r)))
        else begin
            $error("R channel changed while stalled");
            fail_count++;
        end

    reset_idle: assert property (@(posedge ACLK)
        !ARESETn |=> (!w_ready && !r_valid))
        else begin
            $error("w_ready or r_valid high after reset");
            fail_count++;
        end

    b_after_last: assert property (@(posedge ACLK) disable iff (!ARESETn)
        $rose(b_valid) |-> last_seen)
        else begin
            $error("b_valid rose without a last W beat");
            fail_count++;
        end

endmodule

bind axi_burst_sram tb_axi_burst_sram_assert u_assert (.*);

`default_nettype wire
